// File: hdl/cpu16_pkg.sv
package cpu16_pkg;

	// Widths fixed by the instruction format
	localparam int word_width = 16;
	localparam int addr_width = 8;
	localparam int mem_depth = 256;
	localparam int opcode_width = 6;

	typedef logic [word_width-1:0] word_t;
	typedef logic [addr_width-1:0] addr_t;
	typedef logic [opcode_width-1:0] opcode_t;

	// Register select in bits 9:8, a through d
	typedef logic [1:0] reg_sel_t;

	// Opcodes in bits 15:10
	localparam opcode_t op_add = 6'd0;
	localparam opcode_t op_store = 6'd1;
	localparam opcode_t op_load = 6'd2;
	localparam opcode_t op_jump = 6'd3;
	localparam opcode_t op_jneg = 6'd4;
	localparam opcode_t op_subt = 6'd5;
	localparam opcode_t op_jzero = 6'd10;
	localparam opcode_t op_addi = 6'd11;
	localparam opcode_t op_in = 6'd14;
	localparam opcode_t op_out = 6'd15;

	// Source of the value written back to a register
	typedef enum logic [2:0] {
		alu_mem_sum,
		alu_imm_sum,
		alu_imm_diff,
		alu_mem_pass,
		alu_in_pass
	} alu_op_t;

	// Control states
	typedef enum logic [3:0] {
		fetch,
		load_ir,
		decode,
		execute,
		in_wait_ack,
		in_wait_release,
		out_wait_ack,
		out_wait_release
	} state_t;

endpackage

// File: hdl/cpu16_memory.sv
`timescale 1ns/1ns

module cpu16_memory (
	input logic clock,
	input cpu16_pkg::addr_t address,
	input logic write,
	input cpu16_pkg::word_t write_data,
	input logic load_write,
	input cpu16_pkg::addr_t load_address,
	input cpu16_pkg::word_t load_data,
	output cpu16_pkg::word_t read_data
);
	import cpu16_pkg::*;

	word_t storage [mem_depth];
	addr_t read_address;

	// Load port wins over the core port
	always_ff @(posedge clock)
	begin
		if (load_write)
			storage[load_address] <= load_data;
		else if (write)
			storage[address] <= write_data;
	end

	// Registered address, data valid the whole next cycle
	always_ff @(posedge clock)
	begin
		read_address <= address;
	end

	assign read_data = storage[read_address];

endmodule

// File: hdl/cpu16_register_file.sv
`timescale 1ns/1ns

module cpu16_register_file (
	input logic clock,
	input logic reset,
	input cpu16_pkg::reg_sel_t select,
	input logic write,
	input cpu16_pkg::word_t write_data,
	output cpu16_pkg::word_t read_data
);
	import cpu16_pkg::*;

	word_t reg_a;
	word_t reg_b;
	word_t reg_c;
	word_t reg_d;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			reg_a <= '0;
			reg_b <= '0;
			reg_c <= '0;
			reg_d <= '0;
		end
		else if (write)
		begin
			case (select)
				2'd0: reg_a <= write_data;
				2'd1: reg_b <= write_data;
				2'd2: reg_c <= write_data;
				default: reg_d <= write_data;
			endcase
		end
	end

	// Same select drives the write and the read
	always_comb
	begin
		case (select)
			2'd0: read_data = reg_a;
			2'd1: read_data = reg_b;
			2'd2: read_data = reg_c;
			default: read_data = reg_d;
		endcase
	end

endmodule

// File: hdl/cpu16_alu.sv
`timescale 1ns/1ns

module cpu16_alu (
	input cpu16_pkg::alu_op_t op,
	input cpu16_pkg::word_t operand,
	input cpu16_pkg::word_t memory_data,
	input cpu16_pkg::addr_t immediate,
	input cpu16_pkg::word_t in_data,
	output cpu16_pkg::word_t result
);
	import cpu16_pkg::*;

	word_t immediate_word;

	// Immediates are zero-extended
	assign immediate_word = word_t'(immediate);

	// Sums and differences wrap at 16 bits
	always_comb
	begin
		case (op)
			alu_mem_sum:
				result = operand + memory_data;
			alu_imm_sum:
				result = operand + immediate_word;
			alu_imm_diff:
				result = operand - immediate_word;
			alu_mem_pass:
				result = memory_data;
			alu_in_pass:
				result = in_data;
			default:
				result = operand;
		endcase
	end

endmodule

// File: hdl/cpu16_control.sv
`timescale 1ns/1ns

module cpu16_control (
	input logic clock,
	input logic reset,
	input cpu16_pkg::word_t instruction,
	input cpu16_pkg::word_t register_value,
	input logic in_ack,
	input logic out_ack,
	output cpu16_pkg::addr_t program_address,
	output cpu16_pkg::addr_t data_address,
	output logic data_write,
	output cpu16_pkg::reg_sel_t reg_select,
	output logic reg_write,
	output cpu16_pkg::alu_op_t alu_op,
	output cpu16_pkg::addr_t immediate,
	output logic in_req,
	output logic out_req,
	output cpu16_pkg::word_t out_data,
	output cpu16_pkg::addr_t pc
);
	import cpu16_pkg::*;

	state_t state;
	state_t state_next;
	word_t instruction_register;
	addr_t program_counter;
	addr_t operand_field;
	opcode_t opcode;
	logic branch_taken;

	// Instruction fields
	assign opcode = instruction_register[word_width-1 -: opcode_width];
	assign reg_select = instruction_register[9:8];
	assign operand_field = instruction_register[addr_width-1:0];

	assign program_address = program_counter;
	assign pc = program_counter;
	assign data_address = operand_field;
	assign immediate = operand_field;

	// Store writes at the end of decode with the selected register
	assign data_write = (state == decode) && (opcode == op_store);

	always_comb
	begin
		case (opcode)
			op_jump: branch_taken = 1'b1;
			op_jneg: branch_taken = register_value[word_width-1];
			op_jzero: branch_taken = (register_value == '0);
			default: branch_taken = 1'b0;
		endcase
	end

	always_comb
	begin
		case (opcode)
			op_add: alu_op = alu_mem_sum;
			op_addi: alu_op = alu_imm_sum;
			op_subt: alu_op = alu_imm_diff;
			op_in: alu_op = alu_in_pass;
			default: alu_op = alu_mem_pass;
		endcase
	end

	// Register writeback
	always_comb
	begin
		case (state)
			execute:
				reg_write = (opcode == op_add) || (opcode == op_load) ||
					(opcode == op_subt) || (opcode == op_addi);
			in_wait_ack:
				reg_write = in_ack;
			default:
				reg_write = 1'b0;
		endcase
	end

	always_comb
	begin
		state_next = state;
		case (state)
			fetch:
				state_next = load_ir;
			load_ir:
				state_next = decode;
			decode:
				state_next = execute;
			execute:
			begin
				if (opcode == op_in)
					state_next = in_wait_ack;
				else if (opcode == op_out)
					state_next = out_wait_ack;
				else
					state_next = fetch;
			end
			in_wait_ack:
			begin
				if (in_ack)
					state_next = in_wait_release;
			end
			in_wait_release:
			begin
				if (!in_ack)
					state_next = fetch;
			end
			out_wait_ack:
			begin
				if (out_ack)
					state_next = out_wait_release;
			end
			out_wait_release:
			begin
				if (!out_ack)
					state_next = fetch;
			end
			default:
				state_next = fetch;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= fetch;
			program_counter <= '0;
			instruction_register <= '0;
			in_req <= 1'b0;
			out_req <= 1'b0;
			out_data <= '0;
		end
		else
		begin
			state <= state_next;
			case (state)
				load_ir:
				begin
					instruction_register <= instruction;
					program_counter <= program_counter + addr_t'(1);
				end
				execute:
				begin
					if (branch_taken)
						program_counter <= operand_field;
					if (opcode == op_in)
						in_req <= 1'b1;
					// out_data is frozen for the whole request
					if (opcode == op_out)
					begin
						out_req <= 1'b1;
						out_data <= register_value;
					end
				end
				in_wait_ack:
				begin
					if (in_ack)
						in_req <= 1'b0;
				end
				out_wait_ack:
				begin
					if (out_ack)
						out_req <= 1'b0;
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

// File: hdl/cpu16_top.sv
`timescale 1ns/1ns

module cpu16_top (
	input logic clock,
	input logic reset,
	input logic load_write,
	input logic load_target,
	input cpu16_pkg::addr_t load_address,
	input cpu16_pkg::word_t load_data,
	input cpu16_pkg::word_t in_data,
	input logic in_ack,
	input logic out_ack,
	output cpu16_pkg::addr_t pc,
	output logic in_req,
	output logic out_req,
	output cpu16_pkg::word_t out_data
);
	import cpu16_pkg::*;

	word_t instruction;
	word_t data_read;
	word_t register_value;
	word_t alu_result;
	addr_t program_address;
	addr_t data_address;
	addr_t immediate;
	reg_sel_t reg_select;
	alu_op_t alu_op;
	logic data_write;
	logic reg_write;
	logic instruction_load_write;
	logic data_load_write;

	// Target 0 is instruction memory, 1 is data memory
	assign instruction_load_write = load_write && !load_target;
	assign data_load_write = load_write && load_target;

	cpu16_control u_control (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.register_value(register_value),
		.in_ack(in_ack),
		.out_ack(out_ack),
		.program_address(program_address),
		.data_address(data_address),
		.data_write(data_write),
		.reg_select(reg_select),
		.reg_write(reg_write),
		.alu_op(alu_op),
		.immediate(immediate),
		.in_req(in_req),
		.out_req(out_req),
		.out_data(out_data),
		.pc(pc)
	);

	cpu16_register_file u_register_file (
		.clock(clock),
		.reset(reset),
		.select(reg_select),
		.write(reg_write),
		.write_data(alu_result),
		.read_data(register_value)
	);

	cpu16_alu u_alu (
		.op(alu_op),
		.operand(register_value),
		.memory_data(data_read),
		.immediate(immediate),
		.in_data(in_data),
		.result(alu_result)
	);

	// Program memory is read-only to the core
	cpu16_memory u_instruction_memory (
		.clock(clock),
		.address(program_address),
		.write(1'b0),
		.write_data('0),
		.load_write(instruction_load_write),
		.load_address(load_address),
		.load_data(load_data),
		.read_data(instruction)
	);

	cpu16_memory u_data_memory (
		.clock(clock),
		.address(data_address),
		.write(data_write),
		.write_data(register_value),
		.load_write(data_load_write),
		.load_address(load_address),
		.load_data(load_data),
		.read_data(data_read)
	);

endmodule

// File: test/cpu16_tb_clock.sv
`timescale 1ns/1ns

module cpu16_tb_clock (
	input logic hold_reset,
	output logic clock,
	output logic reset
);
	logic power_on_reset;

	// 100 ns period
	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// Power-on reset for three cycles, released on a falling edge
	initial
	begin
		power_on_reset = 1'b1;
		repeat (3)
			@(posedge clock);
		@(negedge clock);
		power_on_reset = 1'b0;
	end

	assign reset = power_on_reset || hold_reset;

endmodule

// File: test/cpu16_tb.sv
`timescale 1ns/1ns

module cpu16_tb;
	import cpu16_pkg::*;

	localparam logic [31:0] random_seed = 32'h35b59fe4;
	localparam int test_count = 6;
	localparam int cycles_per_test = 2000;
	localparam int idle_cycles = 20;

	localparam reg_sel_t sel_a = 2'd0;
	localparam reg_sel_t sel_b = 2'd1;
	localparam reg_sel_t sel_c = 2'd2;
	localparam reg_sel_t sel_d = 2'd3;

	logic clock;
	logic reset;
	logic hold_reset;
	logic load_write;
	logic load_target;
	addr_t load_address;
	word_t load_data;
	word_t in_data;
	logic in_ack;
	logic out_ack;
	addr_t pc;
	logic in_req;
	logic out_req;
	word_t out_data;

	// Program, data image and expected traffic of the current test
	word_t program_words[$];
	addr_t data_addresses[$];
	word_t data_values[$];
	word_t in_words[$];
	word_t expected_outputs[$];

	cpu16_tb_clock u_clock (
		.hold_reset(hold_reset),
		.clock(clock),
		.reset(reset)
	);

	cpu16_top u_cpu16_top (
		.clock(clock),
		.reset(reset),
		.load_write(load_write),
		.load_target(load_target),
		.load_address(load_address),
		.load_data(load_data),
		.in_data(in_data),
		.in_ack(in_ack),
		.out_ack(out_ack),
		.pc(pc),
		.in_req(in_req),
		.out_req(out_req),
		.out_data(out_data)
	);

	task automatic report_failure(input string message);
		$display("%s", message);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string test_name, input string item,
		input word_t expected, input word_t actual);
		if (expected !== actual)
			report_failure($sformatf("CHECK FAILED %s (%s): expected %h, actual %h",
				test_name, item, expected, actual));
	endtask

	task automatic clear_program();
		program_words.delete();
		data_addresses.delete();
		data_values.delete();
		in_words.delete();
		expected_outputs.delete();
	endtask

	// Opcode in 15:10, register in 9:8, address or immediate in 7:0
	task automatic emit(input opcode_t op, input reg_sel_t sel, input addr_t operand);
		program_words.push_back({op, sel, operand});
	endtask

	task automatic preload(input addr_t address, input word_t value);
		data_addresses.push_back(address);
		data_values.push_back(value);
	endtask

	task automatic hold_and_load();
		@(negedge clock);
		hold_reset = 1'b1;
		foreach (program_words[i])
		begin
			@(negedge clock);
			load_write = 1'b1;
			load_target = 1'b0;
			load_address = addr_t'(i);
			load_data = program_words[i];
		end
		foreach (data_addresses[i])
		begin
			@(negedge clock);
			load_write = 1'b1;
			load_target = 1'b1;
			load_address = data_addresses[i];
			load_data = data_values[i];
		end
		@(negedge clock);
		load_write = 1'b0;
	endtask

	task automatic release_reset();
		repeat (3)
			@(negedge clock);
		hold_reset = 1'b0;
	endtask

	// Serves in requests and collects outputs until all expected ones arrived
	task automatic run_program(input string test_name, input int ack_delay_max);
		int in_phase;
		int out_phase;
		int in_delay;
		int out_delay;
		int in_index;
		int out_index;
		word_t held_out;
		in_phase = 0;
		out_phase = 0;
		in_delay = 0;
		out_delay = 0;
		in_index = 0;
		out_index = 0;
		held_out = '0;
		while (out_index < expected_outputs.size())
		begin
			@(negedge clock);
			case (in_phase)
				0:
				begin
					if (in_req)
					begin
						if (in_index >= in_words.size())
							report_failure($sformatf("%s: unexpected input request", test_name));
						else
						begin
							in_data = in_words[in_index];
							in_index++;
							in_delay = $urandom_range(ack_delay_max, 0);
							in_phase = 1;
						end
					end
				end
				1:
				begin
					check_value(test_name, "in_req held", 16'h0001, word_t'(in_req));
					if (in_delay == 0)
					begin
						in_ack = 1'b1;
						in_phase = 2;
					end
					else
						in_delay--;
				end
				default:
				begin
					// Request drops at the first edge that sees the acknowledge
					check_value(test_name, "in_req after ack", 16'h0000, word_t'(in_req));
					in_ack = 1'b0;
					in_phase = 0;
				end
			endcase
			case (out_phase)
				0:
				begin
					if (out_req)
					begin
						held_out = out_data;
						out_delay = $urandom_range(ack_delay_max, 0);
						out_phase = 1;
					end
				end
				1:
				begin
					check_value(test_name, "out_req held", 16'h0001, word_t'(out_req));
					check_value(test_name, "out_data stable", held_out, out_data);
					if (out_delay == 0)
					begin
						out_ack = 1'b1;
						out_phase = 2;
					end
					else
						out_delay--;
				end
				default:
				begin
					check_value(test_name, "out_req after ack", 16'h0000, word_t'(out_req));
					check_value(test_name, $sformatf("output %0d", out_index),
						expected_outputs[out_index], held_out);
					out_index++;
					out_ack = 1'b0;
					out_phase = 0;
				end
			endcase
		end
		check_value(test_name, "inputs consumed", word_t'(in_words.size()), word_t'(in_index));
		// Program parks in its final loop with no further traffic
		repeat (idle_cycles)
		begin
			@(negedge clock);
			check_value(test_name, "no extra out_req", 16'h0000, word_t'(out_req));
			check_value(test_name, "no extra in_req", 16'h0000, word_t'(in_req));
		end
	endtask

	// Parks the core in an unanswered handshake and then applies reset
	task automatic reset_during_request(input opcode_t op);
		clear_program();
		emit(op_addi, sel_a, 8'h5a);
		emit(op, sel_a, 8'h00);
		emit(op_jump, sel_a, 8'd2);
		hold_and_load();
		release_reset();
		while (!in_req && !out_req)
			@(negedge clock);
		hold_reset = 1'b1;
		@(negedge clock);
		check_value("reset", "pc in reset", 16'h0000, word_t'(pc));
		check_value("reset", "in_req in reset", 16'h0000, word_t'(in_req));
		check_value("reset", "out_req in reset", 16'h0000, word_t'(out_req));
		check_value("reset", "out_data in reset", 16'h0000, out_data);
	endtask

	task automatic memory_arithmetic_test();
		word_t first;
		word_t second;
		word_t third;
		word_t sum;
		first = 16'hfff0;
		second = word_t'($urandom);
		third = word_t'($urandom);
		sum = first + second + third;
		clear_program();
		preload(8'h10, first);
		preload(8'h11, second);
		preload(8'h12, third);
		emit(op_load, sel_a, 8'h10);
		emit(op_add, sel_a, 8'h11);
		emit(op_add, sel_a, 8'h12);
		emit(op_store, sel_a, 8'h20);
		emit(op_load, sel_b, 8'h20);
		emit(op_out, sel_b, 8'h00);
		emit(op_out, sel_a, 8'h00);
		emit(op_jump, sel_a, 8'd7);
		expected_outputs.push_back(sum);
		expected_outputs.push_back(sum);
		hold_and_load();
		release_reset();
		run_program("memory arithmetic", 3);
	endtask

	task automatic immediate_arithmetic_test();
		addr_t up;
		addr_t down;
		word_t value_d;
		up = addr_t'($urandom);
		down = addr_t'($urandom);
		value_d = 16'h0000 + {8'h00, up};
		value_d = value_d - {8'h00, down};
		clear_program();
		emit(op_addi, sel_a, 8'h25);
		emit(op_subt, sel_a, 8'h30);
		emit(op_addi, sel_b, 8'hff);
		emit(op_addi, sel_b, 8'h01);
		emit(op_subt, sel_c, 8'h01);
		emit(op_addi, sel_c, 8'h02);
		emit(op_addi, sel_d, up);
		emit(op_subt, sel_d, down);
		emit(op_out, sel_a, 8'h00);
		emit(op_out, sel_b, 8'h00);
		emit(op_out, sel_c, 8'h00);
		emit(op_out, sel_d, 8'h00);
		emit(op_jump, sel_a, 8'd12);
		// Register a goes below zero and c wraps past 0xffff
		expected_outputs.push_back(16'hfff5);
		expected_outputs.push_back(16'h0100);
		expected_outputs.push_back(16'h0001);
		expected_outputs.push_back(value_d);
		hold_and_load();
		release_reset();
		run_program("immediate arithmetic", 3);
	endtask

	task automatic branch_test();
		clear_program();
		preload(8'h30, 16'h8001);
		preload(8'h40, 16'hdead);
		preload(8'h41, 16'h1001);
		preload(8'h42, 16'h1002);
		preload(8'h43, 16'h1003);
		preload(8'h44, 16'h1004);
		preload(8'h45, 16'h1005);
		emit(op_load, sel_b, 8'h30);
		emit(op_addi, sel_d, 8'h05);
		emit(op_jump, sel_a, 8'd5);
		emit(op_load, sel_a, 8'h40);
		emit(op_out, sel_a, 8'h00);
		emit(op_load, sel_a, 8'h41);
		emit(op_out, sel_a, 8'h00);
		// d is positive so this falls through
		emit(op_jneg, sel_d, 8'd10);
		emit(op_load, sel_a, 8'h42);
		emit(op_out, sel_a, 8'h00);
		emit(op_jneg, sel_b, 8'd13);
		emit(op_load, sel_a, 8'h40);
		emit(op_out, sel_a, 8'h00);
		emit(op_load, sel_a, 8'h43);
		emit(op_out, sel_a, 8'h00);
		emit(op_jzero, sel_d, 8'd18);
		emit(op_load, sel_a, 8'h44);
		emit(op_out, sel_a, 8'h00);
		// c is still zero from reset
		emit(op_jzero, sel_c, 8'd21);
		emit(op_load, sel_a, 8'h40);
		emit(op_out, sel_a, 8'h00);
		emit(op_load, sel_a, 8'h45);
		emit(op_out, sel_a, 8'h00);
		emit(op_jump, sel_a, 8'd23);
		expected_outputs.push_back(16'h1001);
		expected_outputs.push_back(16'h1002);
		expected_outputs.push_back(16'h1003);
		expected_outputs.push_back(16'h1004);
		expected_outputs.push_back(16'h1005);
		hold_and_load();
		release_reset();
		run_program("branches", 3);
	endtask

	task automatic input_handshake_test();
		word_t sum;
		clear_program();
		repeat (3)
			in_words.push_back(word_t'($urandom));
		sum = in_words[0] + in_words[1] + in_words[2];
		emit(op_in, sel_a, 8'h00);
		emit(op_store, sel_a, 8'h50);
		emit(op_in, sel_a, 8'h00);
		emit(op_add, sel_a, 8'h50);
		emit(op_store, sel_a, 8'h50);
		emit(op_in, sel_a, 8'h00);
		emit(op_add, sel_a, 8'h50);
		emit(op_out, sel_a, 8'h00);
		emit(op_jump, sel_a, 8'd8);
		expected_outputs.push_back(sum);
		hold_and_load();
		release_reset();
		run_program("input handshake", 8);
	endtask

	task automatic output_backpressure_test();
		addr_t first;
		addr_t second;
		word_t total;
		first = addr_t'($urandom);
		second = addr_t'($urandom);
		total = {8'h00, first} + {8'h00, second};
		clear_program();
		emit(op_addi, sel_a, first);
		emit(op_out, sel_a, 8'h00);
		emit(op_addi, sel_a, second);
		emit(op_out, sel_a, 8'h00);
		emit(op_addi, sel_b, 8'h7f);
		emit(op_out, sel_b, 8'h00);
		emit(op_out, sel_a, 8'h00);
		emit(op_jump, sel_a, 8'd7);
		expected_outputs.push_back({8'h00, first});
		expected_outputs.push_back(total);
		expected_outputs.push_back(16'h007f);
		expected_outputs.push_back(total);
		hold_and_load();
		release_reset();
		run_program("output back-pressure", 24);
	endtask

	task automatic reset_and_unused_test();
		reset_during_request(op_in);
		reset_during_request(op_out);
		clear_program();
		preload(8'h55, 16'h0100);
		preload(8'h10, 16'h0200);
		emit(op_addi, sel_a, 8'h12);
		emit(op_addi, sel_b, 8'h34);
		// Opcodes outside the kept set
		emit(6'd6, sel_a, 8'h55);
		emit(6'd7, sel_b, 8'h10);
		emit(6'd13, sel_a, 8'h20);
		emit(6'd63, sel_b, 8'hff);
		emit(op_out, sel_a, 8'h00);
		emit(op_out, sel_b, 8'h00);
		emit(op_jump, sel_a, 8'd8);
		expected_outputs.push_back(16'h0012);
		expected_outputs.push_back(16'h0034);
		hold_and_load();
		release_reset();
		@(negedge clock);
		check_value("reset", "pc after release", 16'h0000, word_t'(pc));
		run_program("unused opcodes", 3);
	endtask

	initial
	begin
		repeat (test_count * cycles_per_test)
			@(posedge clock);
		report_failure("Watchdog expired: the processor stopped finishing its handshakes");
	end

	initial
	begin
		hold_reset = 1'b0;
		load_write = 1'b0;
		load_target = 1'b0;
		load_address = '0;
		load_data = '0;
		in_data = '0;
		in_ack = 1'b0;
		out_ack = 1'b0;
		void'($urandom(random_seed));
		memory_arithmetic_test();
		immediate_arithmetic_test();
		branch_test();
		input_handshake_test();
		output_backpressure_test();
		reset_and_unused_test();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: verilog.f
hdl/cpu16_pkg.sv
hdl/cpu16_memory.sv
hdl/cpu16_register_file.sv
hdl/cpu16_alu.sv
hdl/cpu16_control.sv
hdl/cpu16_top.sv
test/cpu16_tb_clock.sv
test/cpu16_tb.sv

// File: Makefile
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ns -j 0
TOP_MODULE := cpu16_tb
FILE_LIST := verilog.f
BUILD_DIR := obj_dir
LOG_FILE := simulation.log
PASS_MESSAGE := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP_MODULE) \
		--Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP_MODULE) 2>&1 | tee $(LOG_FILE)
	@if grep -q "$(PASS_MESSAGE)" $(LOG_FILE); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
